//--- design/raster_frame_defines.svh
// shared defines: default resolution, address and depth widths, flush length, pipeline depth
`ifndef RASTER_FRAME_DEFINES_SVH
`define RASTER_FRAME_DEFINES_SVH

// default framebuffer resolution
`define RF_HRES 320
`define RF_VRES 180

// framebuffer address width
`define RF_ADDR_W 27

// full depth word from the rasterizer
`define RF_Z_W 19

// key kept per pixel in the depth RAM, upper bits of the depth word
`define RF_KEY_W 12

// framebuffer colour width (rgb565)
`define RF_SHADE_W 16

// flush length in multiples of the pixel count
`define RF_FLUSH_PASSES 3

// fragment pipeline depth, also the depth RAM read latency
`define RF_PIPE_STAGES 2

`endif

//--- design/raster_frame_pkg.sv
// package raster_frame_pkg: sequencer state type and the depth word union
`default_nettype none

`include "raster_frame_defines.svh"

package raster_frame_pkg;

  // frame sequencer states
  typedef enum logic [1:0] {
    COUNTING,
    FLUSHING,
    CLEARING
  } seq_state_e;

  // depth word seen as compare key plus fraction
  typedef struct packed {
    logic [`RF_KEY_W-1:0]         key;
    logic [`RF_Z_W-`RF_KEY_W-1:0] frac;
  } depth_key_t;

  // same depth word seen as a grey shade
  typedef struct packed {
    logic [`RF_Z_W-`RF_SHADE_W-2:0] unused_hi;
    logic [`RF_SHADE_W-1:0]         shade;
    logic                           unused_lo;
  } depth_shade_t;

  typedef union packed {
    depth_key_t   as_key;
    depth_shade_t as_shade;
  } depth_word_u;

endpackage

`default_nettype wire

//--- design/depth_buffer_ram.sv
// module depth_buffer_ram: per-pixel depth key memory, read-first write port, staged read
`timescale 1ns/1ps
`default_nettype none

`include "raster_frame_defines.svh"

module depth_buffer_ram #(
  parameter int HRES = `RF_HRES,
  parameter int VRES = `RF_VRES
) (
  input  wire                      clk_100_passthrough,
  input  wire                      sys_rst,
  input  wire                      rd_en_i,
  input  wire  [`RF_ADDR_W-1:0]    rd_addr_i,
  input  wire                      wr_en_i,
  input  wire  [`RF_ADDR_W-1:0]    wr_addr_i,
  input  wire  [`RF_KEY_W-1:0]     wr_key_i,
  output logic [`RF_KEY_W-1:0]     rd_key_o
);

  localparam int PIXELS = HRES * VRES;
  localparam int AW = $clog2(PIXELS);
  localparam int STAGES = `RF_PIPE_STAGES;

  logic [`RF_KEY_W-1:0] mem [PIXELS];
  logic [`RF_KEY_W-1:0] rd_pipe [STAGES];

  // empty buffer at power-up, zero key means never drawn
  initial begin
    for (int i = 0; i < PIXELS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk_100_passthrough) begin
    if (wr_en_i) begin
      mem[wr_addr_i[AW-1:0]] <= wr_key_i;
    end
  end

  // read register plus output registers, all held while rd_en_i is low
  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      for (int i = 0; i < STAGES; i++) begin
        rd_pipe[i] <= '0;
      end
    end else if (rd_en_i) begin
      rd_pipe[0] <= mem[rd_addr_i[AW-1:0]];
      for (int i = 1; i < STAGES; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign rd_key_o = rd_pipe[STAGES-1];

  // both fragment and clear writes stay inside the pixel range
  a_wr_in_range: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    wr_en_i |-> wr_addr_i < PIXELS);

endmodule

`default_nettype wire

//--- design/depth_test_stage.sv
// module depth_test_stage: fragment pipeline, depth compare with in-flight bypass, write mux
`timescale 1ns/1ps
`default_nettype none

`include "raster_frame_defines.svh"

module depth_test_stage (
  input  wire                                clk_100_passthrough,
  input  wire                                sys_rst,
  input  wire                                frag_valid_i,
  input  wire  [`RF_ADDR_W-1:0]              frag_addr_i,
  input  wire  raster_frame_pkg::depth_word_u frag_depth_i,
  input  wire                                frag_last_i,
  input  wire                                accept_i,
  input  wire                                clear_valid_i,
  input  wire  [`RF_ADDR_W-1:0]              clear_addr_i,
  input  wire                                fb_ready_i,
  input  wire  [`RF_KEY_W-1:0]               rd_key_i,
  output logic                               frag_ready_o,
  output logic                               rd_en_o,
  output logic [`RF_ADDR_W-1:0]              rd_addr_o,
  output logic                               wr_en_o,
  output logic [`RF_ADDR_W-1:0]              wr_addr_o,
  output logic [`RF_KEY_W-1:0]               wr_key_o,
  output logic                               fb_valid_o,
  output logic [`RF_ADDR_W-1:0]              fb_addr_o,
  output logic [`RF_Z_W-1:0]                 fb_depth_o,
  output logic [`RF_SHADE_W-1:0]             fb_color_o,
  output logic                               clear_taken_o,
  output logic                               last_accepted_o,
  output logic                               frame_done_o
);

  localparam int STAGES = `RF_PIPE_STAGES;
  localparam int LAST = STAGES - 1;

  logic                          advance;
  logic                          frag_fire;
  logic                          pass;
  logic [`RF_KEY_W-1:0]          stored_key;

  // fragment stages, index LAST is the compare stage
  logic [STAGES-1:0]             stg_valid;
  logic [STAGES-1:0]             stg_last;
  logic [`RF_ADDR_W-1:0]         stg_addr [STAGES];
  raster_frame_pkg::depth_word_u stg_depth [STAGES];

  // writes committed on the last STAGES advancing edges, [0] newest
  logic [STAGES-1:0]             hist_valid;
  logic [`RF_ADDR_W-1:0]         hist_addr [STAGES];
  logic [`RF_KEY_W-1:0]          hist_key [STAGES];

  assign frag_ready_o = accept_i && fb_ready_i;
  assign frag_fire = frag_valid_i && frag_ready_o;
  assign advance = fb_ready_i || !fb_valid_o;

  // RAM read runs in lockstep with the fragment stages
  assign rd_en_o = advance;
  assign rd_addr_o = frag_addr_i;

  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      stg_valid <= '0;
      hist_valid <= '0;
    end else if (advance) begin
      stg_valid[0] <= frag_fire;
      hist_valid[0] <= wr_en_o;
      for (int i = 1; i < STAGES; i++) begin
        stg_valid[i] <= stg_valid[i-1];
        hist_valid[i] <= hist_valid[i-1];
      end
    end
  end

  always_ff @(posedge clk_100_passthrough) begin
    if (advance) begin
      stg_addr[0] <= frag_addr_i;
      stg_depth[0] <= frag_depth_i;
      stg_last[0] <= frag_last_i;
      hist_addr[0] <= wr_addr_o;
      hist_key[0] <= wr_key_o;
      for (int i = 1; i < STAGES; i++) begin
        stg_addr[i] <= stg_addr[i-1];
        stg_depth[i] <= stg_depth[i-1];
        stg_last[i] <= stg_last[i-1];
        hist_addr[i] <= hist_addr[i-1];
        hist_key[i] <= hist_key[i-1];
      end
    end
  end

  // the RAM word predates the writes in the history window, newest match wins
  always_comb begin
    stored_key = rd_key_i;
    for (int i = LAST; i >= 0; i--) begin
      if (hist_valid[i] && (hist_addr[i] == stg_addr[LAST])) begin
        stored_key = hist_key[i];
      end
    end
  end

  assign pass = (stored_key == '0) || (stg_depth[LAST].as_key.key < stored_key);

  // clear writes only come while the pipeline is empty
  always_comb begin
    if (clear_valid_i) begin
      fb_valid_o = 1'b1;
      fb_addr_o = clear_addr_i;
      fb_depth_o = '1;
      fb_color_o = '0;
      wr_key_o = '1;
    end else begin
      fb_valid_o = stg_valid[LAST] && pass;
      fb_addr_o = stg_addr[LAST];
      fb_depth_o = stg_depth[LAST];
      fb_color_o = stg_depth[LAST].as_shade.shade;
      wr_key_o = stg_depth[LAST].as_key.key;
    end
  end

  assign wr_en_o = fb_valid_o && fb_ready_i;
  assign wr_addr_o = fb_addr_o;

  assign clear_taken_o = clear_valid_i && fb_ready_i;
  assign last_accepted_o = frag_fire && frag_last_i;
  assign frame_done_o = stg_valid[LAST] && stg_last[LAST] && advance;

  // held write keeps its data, relies on the RAM read hold and the clear counter
  a_fb_hold: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    fb_valid_o && !fb_ready_i |=> fb_valid_o && $stable(fb_addr_o)
      && $stable(fb_depth_o) && $stable(fb_color_o));

  a_clear_empty: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    clear_valid_i |-> stg_valid == '0);

endmodule

`default_nettype wire

//--- design/frame_sequencer.sv
// counting, flushing and clearing FSM with flush and clear counters and frame select
`timescale 1ns/1ps
`default_nettype none

`include "raster_frame_defines.svh"

module frame_sequencer #(
  parameter int HRES = `RF_HRES,
  parameter int VRES = `RF_VRES
) (
  input  wire                    clk_100_passthrough,
  input  wire                    sys_rst,
  input  wire                    fb_ready_i,
  input  wire                    last_accepted_i,
  input  wire                    frame_done_i,
  input  wire                    clear_taken_i,
  output logic                   accept_o,
  output logic                   clear_valid_o,
  output logic [`RF_ADDR_W-1:0]  clear_addr_o,
  output logic                   frame_o
);

  localparam int PIXELS = HRES * VRES;
  localparam int FLUSH_COUNT = `RF_FLUSH_PASSES * PIXELS;
  localparam int CLR_W = $clog2(PIXELS);
  localparam int FLUSH_W = $clog2(FLUSH_COUNT);

  raster_frame_pkg::seq_state_e state_q;
  logic                         draining_q;
  logic [FLUSH_W-1:0]           flush_cnt_q;
  logic [CLR_W-1:0]             clear_cnt_q;
  logic                         frame_q;

  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      state_q <= raster_frame_pkg::COUNTING;
      draining_q <= 1'b0;
      flush_cnt_q <= '0;
      clear_cnt_q <= '0;
      frame_q <= 1'b0;
    end else begin
      case (state_q)
        raster_frame_pkg::COUNTING: begin
          // stop taking fragments once the last one is in
          if (last_accepted_i) begin
            draining_q <= 1'b1;
          end
          if (frame_done_i) begin
            draining_q <= 1'b0;
            flush_cnt_q <= '0;
            state_q <= raster_frame_pkg::FLUSHING;
          end
        end

        raster_frame_pkg::FLUSHING: begin
          // only cycles the framebuffer is ready count toward the flush
          if (fb_ready_i) begin
            if (flush_cnt_q == FLUSH_W'(FLUSH_COUNT - 1)) begin
              state_q <= raster_frame_pkg::CLEARING;
              frame_q <= ~frame_q;
              clear_cnt_q <= '0;
            end else begin
              flush_cnt_q <= flush_cnt_q + 1'b1;
            end
          end
        end

        raster_frame_pkg::CLEARING: begin
          if (clear_taken_i) begin
            if (clear_cnt_q == CLR_W'(PIXELS - 1)) begin
              state_q <= raster_frame_pkg::COUNTING;
            end else begin
              clear_cnt_q <= clear_cnt_q + 1'b1;
            end
          end
        end

        default: begin
          state_q <= raster_frame_pkg::COUNTING;
        end
      endcase
    end
  end

  assign accept_o = (state_q == raster_frame_pkg::COUNTING) && !draining_q;
  assign clear_valid_o = (state_q == raster_frame_pkg::CLEARING);
  assign clear_addr_o = {{(`RF_ADDR_W - CLR_W){1'b0}}, clear_cnt_q};
  assign frame_o = frame_q;

  // a clear write is taken only while offered and inside the pixel range
  a_clear_in_clearing: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    clear_taken_i |-> clear_valid_o && clear_cnt_q < PIXELS);

  // frame select flips only on the way out of flushing
  a_frame_toggle: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    !$stable(frame_o) |-> $past(state_q) == raster_frame_pkg::FLUSHING
      && state_q == raster_frame_pkg::CLEARING);

endmodule

`default_nettype wire

//--- design/raster_frame_top.sv
// module raster_frame_top: frame sequencer, depth test stage and depth RAM
`timescale 1ns/1ps
`default_nettype none

`include "raster_frame_defines.svh"

module raster_frame_top #(
  parameter int HRES = `RF_HRES,
  parameter int VRES = `RF_VRES
) (
  input  wire                                clk_100_passthrough,
  input  wire                                sys_rst,
  input  wire                                frag_valid_i,
  input  wire  [`RF_ADDR_W-1:0]              frag_addr_i,
  input  wire  raster_frame_pkg::depth_word_u frag_depth_i,
  input  wire                                frag_last_i,
  input  wire                                fb_ready_i,
  output logic                               frag_ready_o,
  output logic                               fb_valid_o,
  output logic [`RF_ADDR_W-1:0]              fb_addr_o,
  output logic [`RF_Z_W-1:0]                 fb_depth_o,
  output logic [`RF_SHADE_W-1:0]             fb_color_o,
  output logic                               frame_o
);

  // sequencer to depth stage
  logic                  accept;
  logic                  clear_valid;
  logic [`RF_ADDR_W-1:0] clear_addr;
  logic                  clear_taken;
  logic                  last_accepted;
  logic                  frame_done;

  // depth stage to depth RAM
  logic                  rd_en;
  logic [`RF_ADDR_W-1:0] rd_addr;
  logic [`RF_KEY_W-1:0]  rd_key;
  logic                  wr_en;
  logic [`RF_ADDR_W-1:0] wr_addr;
  logic [`RF_KEY_W-1:0]  wr_key;

  frame_sequencer #(
    .HRES(HRES),
    .VRES(VRES)
  ) i_sequencer (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .fb_ready_i         (fb_ready_i),
    .last_accepted_i    (last_accepted),
    .frame_done_i       (frame_done),
    .clear_taken_i      (clear_taken),
    .accept_o           (accept),
    .clear_valid_o      (clear_valid),
    .clear_addr_o       (clear_addr),
    .frame_o            (frame_o)
  );

  depth_test_stage i_depth_stage (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .frag_valid_i       (frag_valid_i),
    .frag_addr_i        (frag_addr_i),
    .frag_depth_i       (frag_depth_i),
    .frag_last_i        (frag_last_i),
    .accept_i           (accept),
    .clear_valid_i      (clear_valid),
    .clear_addr_i       (clear_addr),
    .fb_ready_i         (fb_ready_i),
    .rd_key_i           (rd_key),
    .frag_ready_o       (frag_ready_o),
    .rd_en_o            (rd_en),
    .rd_addr_o          (rd_addr),
    .wr_en_o            (wr_en),
    .wr_addr_o          (wr_addr),
    .wr_key_o           (wr_key),
    .fb_valid_o         (fb_valid_o),
    .fb_addr_o          (fb_addr_o),
    .fb_depth_o         (fb_depth_o),
    .fb_color_o         (fb_color_o),
    .clear_taken_o      (clear_taken),
    .last_accepted_o    (last_accepted),
    .frame_done_o       (frame_done)
  );

  depth_buffer_ram #(
    .HRES(HRES),
    .VRES(VRES)
  ) i_depth_ram (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .rd_en_i            (rd_en),
    .rd_addr_i          (rd_addr),
    .wr_en_i            (wr_en),
    .wr_addr_i          (wr_addr),
    .wr_key_i           (wr_key),
    .rd_key_o           (rd_key)
  );

endmodule

`default_nettype wire

//--- tests/raster_frame_checker.sv
// z-buffer and frame sequence model that checks every framebuffer write
`timescale 1ns/1ps
`default_nettype none

`include "raster_frame_defines.svh"

module raster_frame_checker #(
  parameter int HRES = 16,
  parameter int VRES = 8
) (
  input  wire                                clk_100_passthrough,
  input  wire                                sys_rst,
  input  wire                                frag_valid_i,
  input  wire                                frag_ready_i,
  input  wire  [`RF_ADDR_W-1:0]              frag_addr_i,
  input  wire  raster_frame_pkg::depth_word_u frag_depth_i,
  input  wire                                frag_last_i,
  input  wire                                fb_ready_i,
  input  wire                                fb_valid_i,
  input  wire  [`RF_ADDR_W-1:0]              fb_addr_i,
  input  wire  [`RF_Z_W-1:0]                 fb_depth_i,
  input  wire  [`RF_SHADE_W-1:0]             fb_color_i,
  input  wire                                frame_i,
  output int                                 data_errors_o,
  output int                                 seq_errors_o,
  output int                                 frames_done_o
);

  localparam int PIXELS = HRES * VRES;
  localparam int FLUSH_COUNT = `RF_FLUSH_PASSES * PIXELS;

  // one key per pixel updated in fragment transfer order
  logic [`RF_KEY_W-1:0]         model_key [PIXELS];
  logic [`RF_ADDR_W-1:0]        exp_addr [$];
  logic [`RF_Z_W-1:0]           exp_depth [$];
  raster_frame_pkg::seq_state_e exp_state;
  logic                         draining;
  logic                         frame_exp;
  int                           drain_cnt;
  int                           flush_cnt;
  int                           clear_cnt;
  int                           data_errs;
  int                           seq_errs;
  int                           frames;
  // write offered without ready on the previous edge
  logic                         held;
  logic [`RF_ADDR_W-1:0]        held_addr;
  logic [`RF_Z_W-1:0]           held_depth;
  logic [`RF_SHADE_W-1:0]       held_color;

  task automatic data_error(input string msg);
    data_errs++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic seq_error(input string msg);
    seq_errs++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic fill_keys(input logic [`RF_KEY_W-1:0] value);
    for (int i = 0; i < PIXELS; i++) begin
      model_key[i] = value;
    end
  endtask

  // sequential depth test where passing fragments queue their write
  task automatic model_fragment();
    int                   idx;
    logic [`RF_Z_W-1:0]   word;
    logic [`RF_KEY_W-1:0] key;
    idx = int'(frag_addr_i);
    word = frag_depth_i;
    // key is the top of the depth word
    key = word[`RF_Z_W-1 -: `RF_KEY_W];
    if (model_key[idx] == '0 || key < model_key[idx]) begin
      model_key[idx] = key;
      exp_addr.push_back(frag_addr_i);
      exp_depth.push_back(word);
    end
    if (frag_last_i) begin
      draining = 1'b1;
      drain_cnt = 0;
    end
  endtask

  task automatic check_fragment_write();
    logic [`RF_Z_W-1:0]     depth;
    logic [`RF_SHADE_W-1:0] color;
    logic [`RF_ADDR_W-1:0]  addr;
    if (exp_addr.size() == 0) begin
      data_error($sformatf("unexpected write addr %0d depth %h", fb_addr_i, fb_depth_i));
    end else begin
      addr = exp_addr.pop_front();
      depth = exp_depth.pop_front();
      // shade sits just above the lowest depth bit
      color = depth[`RF_SHADE_W:1];
      if (fb_addr_i !== addr || fb_depth_i !== depth || fb_color_i !== color) begin
        data_error($sformatf("write addr %0d depth %h color %h, expected %0d %h %h",
          fb_addr_i, fb_depth_i, fb_color_i, addr, depth, color));
      end
    end
  endtask

  task automatic check_clear_write();
    if (int'(fb_addr_i) != clear_cnt || fb_depth_i !== '1 || fb_color_i !== '0) begin
      data_error($sformatf("clear write addr %0d depth %h color %h, expected addr %0d",
        fb_addr_i, fb_depth_i, fb_color_i, clear_cnt));
    end
  endtask

  always @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      exp_state = raster_frame_pkg::COUNTING;
      draining = 1'b0;
      frame_exp = 1'b0;
      held = 1'b0;
      drain_cnt = 0;
      flush_cnt = 0;
      clear_cnt = 0;
      exp_addr.delete();
      exp_depth.delete();
      fill_keys('0);
    end else begin
      if (frag_ready_i !== (exp_state == raster_frame_pkg::COUNTING && !draining
          && fb_ready_i)) begin
        seq_error($sformatf("frag_ready_o is %b in state %s", frag_ready_i, exp_state.name()));
      end
      if (frame_i !== frame_exp) begin
        seq_error($sformatf("frame_o is %b, expected %b", frame_i, frame_exp));
      end
      if (held && (!fb_valid_i || fb_addr_i !== held_addr || fb_depth_i !== held_depth
          || fb_color_i !== held_color)) begin
        seq_error("held write dropped or changed under back-pressure");
      end
      held = fb_valid_i && !fb_ready_i;
      held_addr = fb_addr_i;
      held_depth = fb_depth_i;
      held_color = fb_color_i;

      case (exp_state)
        raster_frame_pkg::COUNTING: begin
          if (fb_valid_i && fb_ready_i) begin
            check_fragment_write();
          end
          // last fragment leaves the final stage on its STAGES-th advancing edge
          if (draining && (fb_ready_i || !fb_valid_i)) begin
            drain_cnt++;
            if (drain_cnt == `RF_PIPE_STAGES) begin
              if (exp_addr.size() != 0) begin
                data_error($sformatf("%0d expected writes missing at frame end",
                  exp_addr.size()));
                exp_addr.delete();
                exp_depth.delete();
              end
              draining = 1'b0;
              flush_cnt = 0;
              exp_state = raster_frame_pkg::FLUSHING;
            end
          end
          if (frag_valid_i && frag_ready_i) begin
            model_fragment();
          end
        end

        raster_frame_pkg::FLUSHING: begin
          if (fb_valid_i) begin
            seq_error("framebuffer write during flush");
          end
          if (fb_ready_i) begin
            flush_cnt++;
            if (flush_cnt == FLUSH_COUNT) begin
              exp_state = raster_frame_pkg::CLEARING;
              frame_exp = !frame_exp;
              clear_cnt = 0;
            end
          end
        end

        raster_frame_pkg::CLEARING: begin
          if (!fb_valid_i) begin
            seq_error("no clear write offered while clearing");
          end else if (fb_ready_i) begin
            check_clear_write();
            clear_cnt++;
            if (clear_cnt == PIXELS) begin
              exp_state = raster_frame_pkg::COUNTING;
              fill_keys('1);
              frames++;
            end
          end
        end

        default: begin
          seq_error("model left its state range");
        end
      endcase
    end
    data_errors_o <= data_errs;
    seq_errors_o <= seq_errs;
    frames_done_o <= frames;
  end

endmodule

`default_nettype wire

//--- tests/raster_frame_tb.sv
// module raster_frame_tb: clock, reset, seeded random fragments and back-pressure, DUT, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "raster_frame_defines.svh"

module raster_frame_tb;

  localparam int HRES = 16;
  localparam int VRES = 8;
  localparam int PIXELS = HRES * VRES;
  localparam int FRAMES = 2;
  localparam int FRAGS_PER_FRAME = 200;
  localparam int RESET_CYCLES = 5;
  // fragments plus flush and clear cycles per frame
  localparam int FRAME_CYCLES = FRAGS_PER_FRAME + (`RF_FLUSH_PASSES + 1) * PIXELS;
  localparam int TIMEOUT_CYCLES = 4 * FRAMES * FRAME_CYCLES;

  logic                          clk_100_passthrough;
  logic                          sys_rst;
  logic                          frag_valid;
  logic [`RF_ADDR_W-1:0]         frag_addr;
  raster_frame_pkg::depth_word_u frag_depth;
  logic                          frag_last;
  logic                          fb_ready;
  logic                          frag_ready;
  logic                          fb_valid;
  logic [`RF_ADDR_W-1:0]         fb_addr;
  logic [`RF_Z_W-1:0]            fb_depth;
  logic [`RF_SHADE_W-1:0]        fb_color;
  logic                          frame;
  int                            data_errors;
  int                            seq_errors;
  int                            frames_done;

  raster_frame_top #(
    .HRES(HRES),
    .VRES(VRES)
  ) i_dut (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .frag_valid_i       (frag_valid),
    .frag_addr_i        (frag_addr),
    .frag_depth_i       (frag_depth),
    .frag_last_i        (frag_last),
    .fb_ready_i         (fb_ready),
    .frag_ready_o       (frag_ready),
    .fb_valid_o         (fb_valid),
    .fb_addr_o          (fb_addr),
    .fb_depth_o         (fb_depth),
    .fb_color_o         (fb_color),
    .frame_o            (frame)
  );

  raster_frame_checker #(
    .HRES(HRES),
    .VRES(VRES)
  ) i_checker (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .frag_valid_i       (frag_valid),
    .frag_ready_i       (frag_ready),
    .frag_addr_i        (frag_addr),
    .frag_depth_i       (frag_depth),
    .frag_last_i        (frag_last),
    .fb_ready_i         (fb_ready),
    .fb_valid_i         (fb_valid),
    .fb_addr_i          (fb_addr),
    .fb_depth_i         (fb_depth),
    .fb_color_i         (fb_color),
    .frame_i            (frame),
    .data_errors_o      (data_errors),
    .seq_errors_o       (seq_errors),
    .frames_done_o      (frames_done)
  );

  initial begin
    clk_100_passthrough = 1'b0;
    forever begin
      #5 clk_100_passthrough = ~clk_100_passthrough;
    end
  end

  // framebuffer ready about three cycles in four
  function automatic logic draw_ready();
    return $urandom_range(3) != 0;
  endfunction

  // offer fragments until count of them have transferred, valid held until taken
  task automatic send_frame(input int count);
    int          sent;
    logic        fired;
    logic [31:0] rnd;
    sent = 0;
    while (sent < count) begin
      @(posedge clk_100_passthrough);
      fired = frag_valid && frag_ready;
      if (fired) begin
        sent++;
      end
      if (!frag_valid || fired) begin
        if (sent == count || $urandom_range(4) == 0) begin
          frag_valid <= 1'b0;
          frag_last <= 1'b0;
        end else begin
          frag_valid <= 1'b1;
          frag_last <= (sent == count - 1);
          // keep the address now and then to hit the in-flight bypass
          if (sent == 0 || $urandom_range(3) != 0) begin
            rnd = $urandom_range(PIXELS - 1);
            frag_addr <= rnd[`RF_ADDR_W-1:0];
          end
          rnd = $urandom;
          frag_depth <= rnd[`RF_Z_W-1:0];
        end
      end
      fb_ready <= draw_ready();
    end
  endtask

  initial begin : stimulus
    void'($urandom(32'h1acd_12c2));
    sys_rst = 1'b1;
    frag_valid = 1'b0;
    frag_addr = '0;
    frag_depth = '0;
    frag_last = 1'b0;
    fb_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_100_passthrough);
    sys_rst <= 1'b0;
    for (int f = 0; f < FRAMES; f++) begin
      send_frame(FRAGS_PER_FRAME);
    end
    // keep the back-pressure going through the last flush and clear
    while (frames_done < FRAMES) begin
      @(posedge clk_100_passthrough);
      fb_ready <= draw_ready();
    end
    repeat (4) @(posedge clk_100_passthrough);
    $display("errors: %0d data, %0d sequence, %0d frames completed",
      data_errors, seq_errors, frames_done);
    if (data_errors == 0 && seq_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk_100_passthrough);
    $display("timeout: only %0d of %0d frames completed within %0d cycles",
      frames_done, FRAMES, TIMEOUT_CYCLES);
    $display("errors: %0d data, %0d sequence, %0d frames completed",
      data_errors, seq_errors, frames_done);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- raster_frame.f
+incdir+design
design/raster_frame_pkg.sv
design/depth_buffer_ram.sv
design/depth_test_stage.sv
design/frame_sequencer.sv
design/raster_frame_top.sv
tests/raster_frame_checker.sv
tests/raster_frame_tb.sv
